// File: src.f
dcfifo_pkg.sv
dcfifo_ptr_sync.sv
dcfifo_mem.sv
dcfifo_write_side.sv
dcfifo_read_side.sv
dcfifo_top.sv
tb_dcfifo.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_dcfifo -f src.f -o sim_dcfifo

sim_output=$(./obj_dir/sim_dcfifo)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: tb_dcfifo.sv
// Testbench for the dual-clock streaming FIFO
// Random stream against a queue model, capacity, fill levels,
// CSR thresholds and status streams, with a watchdog
`default_nettype none

module tb_dcfifo
    import dcfifo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IN_PERIOD   = 20;
    localparam int OUT_PERIOD  = 26;
    localparam int NUM_BEATS   = 420;
    // Out cycles allowed for the stored beats to leave after the last write
    localparam int DRAIN_LIMIT = 4 * FIFO_DEPTH;
    localparam int WATCHDOG_NS = NUM_BEATS * 30 * OUT_PERIOD + 20000;
    localparam logic [31:0] SEED = 32'h6ec8_10c1;

    logic      in_clk, in_reset_n, out_clk, out_reset_n;
    data_t     in_data, out_data;
    logic      in_sop, in_eop, in_valid, in_ready;
    logic      out_sop, out_eop, out_valid, out_ready;
    logic      in_csr_address, in_csr_read, in_csr_write;
    logic      out_csr_address, out_csr_read, out_csr_write;
    csr_data_t in_csr_writedata, in_csr_readdata, out_csr_writedata, out_csr_readdata;
    logic      almost_full_valid, almost_full_data, almost_empty_valid, almost_empty_data;

    // Model of accepted beats packed as {sop, eop, data}
    payload_t    model_q [$];
    payload_t    head_beat;
    int          accepted_count;
    int          error_count;
    int          check_count;
    logic        input_done;
    logic [31:0] in_seed;
    logic [31:0] out_seed;
    csr_data_t   rd;
    csr_data_t   value;

    dcfifo_top #(.SYNC_DEPTH(2)) UUT (.*);

    initial begin
        in_clk = 1'b0;
        forever #(IN_PERIOD / 2) in_clk = ~in_clk;
    end

    initial begin
        out_clk = 1'b0;
        forever #(OUT_PERIOD / 2) out_clk = ~out_clk;
    end

    // ------------------------------------------------------------
    // Random numbers and compare tasks
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("[FAIL] %0.1f ns: %s got %0h expected %0h", $realtime, what, got, exp);
    endtask

    task automatic check_data(input data_t got_data, input logic got_sop, input logic got_eop,
                              input data_t exp_data, input logic exp_sop, input logic exp_eop);
        check_count++;
        if (got_data !== exp_data || got_sop !== exp_sop || got_eop !== exp_eop) begin
            report_mismatch("output beat {sop,eop,data}", {22'd0, got_sop, got_eop, got_data},
                            {22'd0, exp_sop, exp_eop, exp_data});
        end
    endtask

    task automatic check_level(input level_t got, input level_t exp, input string what);
        check_count++;
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_csr(input csr_data_t got, input csr_data_t exp, input string what);
        check_count++;
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    // ------------------------------------------------------------
    // Monitors feeding and checking the queue model
    // ------------------------------------------------------------
    always @(posedge in_clk) begin
        if (in_valid && in_ready) begin
            model_q.push_back({in_sop, in_eop, in_data});
            accepted_count++;
        end
    end

    always @(posedge out_clk) begin
        if (out_valid && out_ready) begin
            if (model_q.size() == 0) begin
                error_count++;
                $display("Output gave a beat at %0.1f ns while none was expected", $realtime);
            end else begin
                head_beat = model_q.pop_front();
                check_data(out_data, out_sop, out_eop, head_beat[DATA_WIDTH-1:0],
                           head_beat[DATA_WIDTH+1], head_beat[DATA_WIDTH]);
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic next_in_beat();
        in_seed = lcg_next(in_seed);
        in_data <= in_seed[27:20];
        in_sop  <= in_seed[19];
        in_eop  <= in_seed[18];
    endtask

    // Status data bits stay low in reset and valid bits rise after it
    task automatic apply_reset();
        @(posedge out_clk);
        out_ready <= 1'b0;
        @(posedge in_clk);
        in_valid    <= 1'b0;
        in_reset_n  <= 1'b0;
        out_reset_n <= 1'b0;
        model_q.delete();
        accepted_count = 0;
        repeat (8) @(posedge in_clk);
        check_flag(almost_full_valid, 1'b0, "almost_full_valid in reset");
        check_flag(almost_full_data, 1'b0, "almost_full_data in reset");
        check_flag(almost_empty_valid, 1'b0, "almost_empty_valid in reset");
        check_flag(almost_empty_data, 1'b0, "almost_empty_data in reset");
        in_reset_n <= 1'b1;
        @(posedge out_clk);
        out_reset_n <= 1'b1;
        repeat (4) @(posedge in_clk);
        check_flag(almost_full_valid, 1'b1, "almost_full_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        @(posedge out_clk);
        check_flag(almost_empty_valid, 1'b1, "almost_empty_valid after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");
    endtask

    // Optional write and then a read whose data is sampled a cycle later
    task automatic in_csr_access(input logic addr, input logic do_write,
                                 input csr_data_t wdata, output csr_data_t rdata);
        @(posedge in_clk);
        in_csr_address <= addr;
        if (do_write) begin
            in_csr_writedata <= wdata;
            in_csr_write     <= 1'b1;
            @(posedge in_clk);
            in_csr_write <= 1'b0;
        end
        in_csr_read <= 1'b1;
        @(posedge in_clk);
        in_csr_read <= 1'b0;
        @(posedge in_clk);
        rdata = in_csr_readdata;
    endtask

    task automatic out_csr_access(input logic addr, input logic do_write,
                                  input csr_data_t wdata, output csr_data_t rdata);
        @(posedge out_clk);
        out_csr_address <= addr;
        if (do_write) begin
            out_csr_writedata <= wdata;
            out_csr_write     <= 1'b1;
            @(posedge out_clk);
            out_csr_write <= 1'b0;
        end
        out_csr_read <= 1'b1;
        @(posedge out_clk);
        out_csr_read <= 1'b0;
        @(posedge out_clk);
        rdata = out_csr_readdata;
    endtask

    // Data holds while a beat waits for in_ready
    task automatic drive_input_stream();
        int sent;
        sent = 0;
        while (sent < NUM_BEATS) begin
            @(posedge in_clk);
            if (in_valid && in_ready) sent++;
            if (!in_valid || in_ready) begin
                in_seed = lcg_next(in_seed);
                in_valid <= (sent < NUM_BEATS) && (in_seed[29:28] != 2'b00);
                next_in_beat();
            end
        end
        input_done = 1'b1;
    endtask

    // Random back-pressure while beats go in, then drain with out_ready high
    task automatic drive_output_stream();
        int drain_cycles;
        drain_cycles = 0;
        while (!input_done) begin
            @(posedge out_clk);
            out_seed = lcg_next(out_seed);
            out_ready <= out_seed[28];
        end
        @(posedge out_clk);
        out_ready <= 1'b1;
        while (model_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge out_clk);
            drain_cycles++;
        end
    endtask

    task automatic check_almost_full(input threshold_t thr, input logic exp);
        csr_data_t unused_rd;
        in_csr_access(CSR_ADDR_THRESHOLD, 1'b1, csr_data_t'(thr), unused_rd);
        @(posedge in_clk);
        check_flag(almost_full_data, exp, "almost_full_data");
    endtask

    task automatic check_almost_empty(input threshold_t thr, input logic exp);
        csr_data_t unused_rd;
        out_csr_access(CSR_ADDR_THRESHOLD, 1'b1, csr_data_t'(thr), unused_rd);
        @(posedge out_clk);
        check_flag(almost_empty_data, exp, "almost_empty_data");
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        in_reset_n <= 1'b0;
        out_reset_n <= 1'b0;
        in_data <= '0;
        in_sop <= 1'b0;
        in_eop <= 1'b0;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        in_csr_address <= 1'b0;
        in_csr_read <= 1'b0;
        in_csr_write <= 1'b0;
        in_csr_writedata <= '0;
        out_csr_address <= 1'b0;
        out_csr_read <= 1'b0;
        out_csr_write <= 1'b0;
        out_csr_writedata <= '0;
        error_count = 0;
        check_count = 0;
        accepted_count = 0;
        input_done = 1'b0;
        in_seed = SEED;
        out_seed = lcg_next(SEED ^ 32'h0000_ffff);

        apply_reset();
        check_csr(in_csr_readdata, '0, "input readdata after reset");
        check_csr(out_csr_readdata, '0, "output readdata after reset");
        in_csr_access(CSR_ADDR_THRESHOLD, 1'b0, '0, rd);
        check_csr(rd, '0, "almost-full threshold after reset");
        out_csr_access(CSR_ADDR_THRESHOLD, 1'b0, '0, rd);
        check_csr(rd, '0, "almost-empty threshold after reset");

        // Threshold read back with the top byte always zero
        repeat (4) begin
            in_seed = lcg_next(in_seed);
            value = in_seed;
            in_csr_access(CSR_ADDR_THRESHOLD, 1'b1, value, rd);
            check_csr(rd, csr_data_t'(value[THRESHOLD_WIDTH-1:0]), "almost-full threshold");
            out_seed = lcg_next(out_seed);
            value = out_seed;
            out_csr_access(CSR_ADDR_THRESHOLD, 1'b1, value, rd);
            check_csr(rd, csr_data_t'(value[THRESHOLD_WIDTH-1:0]), "almost-empty threshold");
        end

        // Random stream in both directions
        fork
            drive_input_stream();
            drive_output_stream();
        join
        check_flag(model_q.size() == 0, 1'b1, "model queue empty after stream");

        // Capacity with the output stalled
        apply_reset();
        @(posedge in_clk);
        in_valid <= 1'b1;
        next_in_beat();
        repeat (40) begin
            @(posedge in_clk);
            if (in_valid && in_ready) next_in_beat();
        end
        repeat (20) @(posedge out_clk);
        @(negedge in_clk);
        check_level(level_t'(accepted_count), level_t'(FIFO_DEPTH + 1), "beats accepted");
        check_flag(in_ready, 1'b0, "in_ready when full");

        // Fill levels and status around each threshold
        in_csr_access(CSR_ADDR_LEVEL, 1'b0, '0, rd);
        check_csr(rd, csr_data_t'(FIFO_DEPTH), "input fill level when full");
        out_csr_access(CSR_ADDR_LEVEL, 1'b0, '0, rd);
        check_csr(rd, csr_data_t'(FIFO_DEPTH + 1), "output fill level when full");
        // In level is 16 and out level is 17 in the stalled state
        for (int t = FIFO_DEPTH - 1; t <= FIFO_DEPTH + 2; t++) begin
            check_almost_full(threshold_t'(t), t <= FIFO_DEPTH);
            check_almost_empty(threshold_t'(t), t >= FIFO_DEPTH + 1);
        end

        // Drain and settle until both levels are back to zero
        @(posedge in_clk);
        in_valid <= 1'b0;
        @(posedge out_clk);
        out_ready <= 1'b1;
        while (model_q.size() != 0) @(posedge out_clk);
        repeat (20) @(posedge out_clk);
        in_csr_access(CSR_ADDR_LEVEL, 1'b0, '0, rd);
        check_csr(rd, '0, "input fill level after drain");
        out_csr_access(CSR_ADDR_LEVEL, 1'b0, '0, rd);
        check_csr(rd, '0, "output fill level after drain");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the stream length
    initial begin
        #(WATCHDOG_NS);
        $display("Timed out: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcfifo_top.sv
// Top level of the dual-clock streaming FIFO
// Write side, read side, payload memory and two pointer crossers
`default_nettype none

module dcfifo_top
    import dcfifo_pkg::*;
#(
    parameter int SYNC_DEPTH = 2
) (
    input  wire            in_clk,
    input  wire            in_reset_n,
    input  wire            out_clk,
    input  wire            out_reset_n,
    // Write stream
    input  wire data_t     in_data,
    input  wire            in_sop,
    input  wire            in_eop,
    input  wire            in_valid,
    output logic           in_ready,
    // Read stream
    output data_t          out_data,
    output logic           out_sop,
    output logic           out_eop,
    output logic           out_valid,
    input  wire            out_ready,
    // Input CSR, in_clk domain
    input  wire            in_csr_address,
    input  wire            in_csr_read,
    input  wire            in_csr_write,
    input  wire csr_data_t in_csr_writedata,
    output csr_data_t      in_csr_readdata,
    // Output CSR, out_clk domain
    input  wire            out_csr_address,
    input  wire            out_csr_read,
    input  wire            out_csr_write,
    input  wire csr_data_t out_csr_writedata,
    output csr_data_t      out_csr_readdata,
    // Status streams
    output logic           almost_full_valid,
    output logic           almost_full_data,
    output logic           almost_empty_valid,
    output logic           almost_empty_data
);

    // Binary pointers, native and synchronized
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    ptr_t     wr_ptr_sync;
    ptr_t     rd_ptr_sync;
    // Memory ports
    logic     mem_wr_en;
    addr_t    mem_wr_addr;
    payload_t mem_wr_payload;
    addr_t    mem_rd_addr;
    payload_t mem_rd_payload;

    // ----------------------------------------------------------
    // Write domain
    // ----------------------------------------------------------
    dcfifo_write_side write_side (
        .in_clk, .in_reset_n,
        .in_data, .in_sop, .in_eop, .in_valid,
        .rd_ptr_sync,
        .in_csr_address, .in_csr_read, .in_csr_write, .in_csr_writedata,
        .in_ready, .wr_ptr,
        .mem_wr_en, .mem_wr_addr, .mem_wr_payload,
        .in_csr_readdata, .almost_full_valid, .almost_full_data
    );

    // Write pointer into the read domain
    dcfifo_ptr_sync #(.SYNC_DEPTH(SYNC_DEPTH)) write_crosser (
        .src_clk     (in_clk),
        .src_reset_n (in_reset_n),
        .dst_clk     (out_clk),
        .dst_reset_n (out_reset_n),
        .src_ptr     (wr_ptr),
        .dst_ptr     (wr_ptr_sync)
    );

    dcfifo_mem mem (
        .in_clk, .out_clk,
        .wr_en      (mem_wr_en),
        .wr_addr    (mem_wr_addr),
        .wr_payload (mem_wr_payload),
        .rd_addr    (mem_rd_addr),
        .rd_payload (mem_rd_payload)
    );

    // ----------------------------------------------------------
    // Read domain
    // ----------------------------------------------------------
    dcfifo_read_side read_side (
        .out_clk, .out_reset_n,
        .wr_ptr_sync, .mem_rd_payload, .out_ready,
        .out_csr_address, .out_csr_read, .out_csr_write, .out_csr_writedata,
        .rd_ptr, .mem_rd_addr,
        .out_data, .out_sop, .out_eop, .out_valid,
        .out_csr_readdata, .almost_empty_valid, .almost_empty_data
    );

    // Read pointer back into the write domain
    dcfifo_ptr_sync #(.SYNC_DEPTH(SYNC_DEPTH)) read_crosser (
        .src_clk     (out_clk),
        .src_reset_n (out_reset_n),
        .dst_clk     (in_clk),
        .dst_reset_n (in_reset_n),
        .src_ptr     (rd_ptr),
        .dst_ptr     (rd_ptr_sync)
    );

endmodule

`default_nettype wire

// File: dcfifo_read_side.sv
// Read side of the dual-clock FIFO: read pointer, empty flag,
// output register stage, output fill level, almost-empty status
// and output CSR
`default_nettype none

module dcfifo_read_side
    import dcfifo_pkg::*;
(
    input  wire            out_clk,
    input  wire            out_reset_n,
    input  wire ptr_t      wr_ptr_sync,
    input  wire payload_t  mem_rd_payload,
    input  wire            out_ready,
    input  wire            out_csr_address,
    input  wire            out_csr_read,
    input  wire            out_csr_write,
    input  wire csr_data_t out_csr_writedata,
    output ptr_t           rd_ptr,
    output addr_t          mem_rd_addr,
    output data_t          out_data,
    output logic           out_sop,
    output logic           out_eop,
    output logic           out_valid,
    output csr_data_t      out_csr_readdata,
    output logic           almost_empty_valid,
    output logic           almost_empty_data
);

    logic       empty;
    logic       stage_load;
    logic       take;
    ptr_t       next_rd_ptr;
    payload_t   out_payload;
    level_t     mem_fill_level;
    level_t     out_fill_level;
    threshold_t almost_empty_threshold;

    // ----------------------------------------------------------
    // Read pointer and empty flag
    // ----------------------------------------------------------
    // Stage takes a new word when drained or about to be drained
    assign stage_load = out_ready || !out_valid;
    // A word leaves memory when there is one and the stage loads
    assign take       = stage_load && !empty;

    assign next_rd_ptr = take ? rd_ptr + ptr_t'(1) : rd_ptr;

    // Memory reads ahead at the next pointer, head appears a cycle later
    assign mem_rd_addr = next_rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr <= '0;
            empty  <= 1'b1;
        end else begin
            rd_ptr <= next_rd_ptr;
            empty  <= (next_rd_ptr == wr_ptr_sync);
        end
    end

    // ----------------------------------------------------------
    // Output register stage
    // ----------------------------------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_load) begin
            out_valid <= !empty;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge out_clk) begin
        if (stage_load) begin
            out_payload <= mem_rd_payload;
        end
    end

    assign {out_sop, out_eop, out_data} = out_payload;

    // ----------------------------------------------------------
    // Output fill level
    // ----------------------------------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            mem_fill_level <= '0;
        end else begin
            mem_fill_level <= wr_ptr_sync - next_rd_ptr;
        end
    end

    // Count the word in the output stage too, 17 when fully stalled
    assign out_fill_level = mem_fill_level + level_t'(out_valid);

    // ----------------------------------------------------------
    // Output CSR
    // ----------------------------------------------------------
    // Write has priority, readdata updates on reads only
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_csr_readdata       <= '0;
            almost_empty_threshold <= '0;
        end else if (out_csr_write) begin
            // Writes to the level address are dropped
            if (out_csr_address == CSR_ADDR_THRESHOLD) begin
                almost_empty_threshold <= out_csr_writedata[THRESHOLD_WIDTH-1:0];
            end
        end else if (out_csr_read) begin
            if (out_csr_address == CSR_ADDR_LEVEL) begin
                out_csr_readdata <= csr_data_t'(out_fill_level);
            end else begin
                out_csr_readdata <= csr_data_t'(almost_empty_threshold);
            end
        end
    end

    // Almost-empty status stream
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            almost_empty_valid <= 1'b0;
            almost_empty_data  <= 1'b0;
        end else begin
            almost_empty_valid <= 1'b1;
            almost_empty_data  <= threshold_t'(out_fill_level) <= almost_empty_threshold;
        end
    end

endmodule

`default_nettype wire

// File: dcfifo_write_side.sv
// Write side of the dual-clock FIFO: write pointer, full flag,
// input fill level, almost-full status and input CSR
`default_nettype none

module dcfifo_write_side
    import dcfifo_pkg::*;
(
    input  wire            in_clk,
    input  wire            in_reset_n,
    input  wire data_t     in_data,
    input  wire            in_sop,
    input  wire            in_eop,
    input  wire            in_valid,
    input  wire ptr_t      rd_ptr_sync,
    input  wire            in_csr_address,
    input  wire            in_csr_read,
    input  wire            in_csr_write,
    input  wire csr_data_t in_csr_writedata,
    output logic           in_ready,
    output ptr_t           wr_ptr,
    output logic           mem_wr_en,
    output addr_t          mem_wr_addr,
    output payload_t       mem_wr_payload,
    output csr_data_t      in_csr_readdata,
    output logic           almost_full_valid,
    output logic           almost_full_data
);

    logic       full;
    logic       accept;
    ptr_t       next_wr_ptr;
    level_t     in_fill_level;
    threshold_t almost_full_threshold;

    // ----------------------------------------------------------
    // Sink handshake and memory write
    // ----------------------------------------------------------
    assign in_ready = !full;
    assign accept   = in_valid && in_ready;

    assign mem_wr_en      = accept;
    assign mem_wr_addr    = wr_ptr[ADDR_WIDTH-1:0];
    assign mem_wr_payload = {in_sop, in_eop, in_data};

    assign next_wr_ptr = accept ? wr_ptr + ptr_t'(1) : wr_ptr;

    // ----------------------------------------------------------
    // Write pointer and full flag
    // ----------------------------------------------------------
    // Full when addresses match and wrap bits differ
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else begin
            wr_ptr <= next_wr_ptr;
            full   <= (next_wr_ptr[ADDR_WIDTH-1:0] == rd_ptr_sync[ADDR_WIDTH-1:0]) &&
                      (next_wr_ptr[ADDR_WIDTH] != rd_ptr_sync[ADDR_WIDTH]);
        end
    end

    // Input fill level covers the memory only, not the output stage
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            in_fill_level <= '0;
        end else begin
            in_fill_level <= next_wr_ptr - rd_ptr_sync;
        end
    end

    // ----------------------------------------------------------
    // Input CSR
    // ----------------------------------------------------------
    // Write wins over read in the same cycle
    // Readdata holds until the next read
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            in_csr_readdata       <= '0;
            almost_full_threshold <= '0;
        end else if (in_csr_write) begin
            // Level register is read only
            if (in_csr_address == CSR_ADDR_THRESHOLD) begin
                almost_full_threshold <= in_csr_writedata[THRESHOLD_WIDTH-1:0];
            end
        end else if (in_csr_read) begin
            // Upper byte always reads zero
            if (in_csr_address == CSR_ADDR_LEVEL) begin
                in_csr_readdata <= csr_data_t'(in_fill_level);
            end else begin
                in_csr_readdata <= csr_data_t'(almost_full_threshold);
            end
        end
    end

    // Almost-full status stream
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            almost_full_valid <= 1'b0;
            almost_full_data  <= 1'b0;
        end else begin
            almost_full_valid <= 1'b1;
            almost_full_data  <= threshold_t'(in_fill_level) >= almost_full_threshold;
        end
    end

endmodule

`default_nettype wire

// File: dcfifo_mem.sv
// Dual-clock payload memory
// Write on in_clk, registered read on out_clk
`default_nettype none

module dcfifo_mem
    import dcfifo_pkg::*;
(
    input  wire           in_clk,
    input  wire           out_clk,
    input  wire           wr_en,
    input  wire addr_t    wr_addr,
    input  wire payload_t wr_payload,
    input  wire addr_t    rd_addr,
    output payload_t      rd_payload
);

    payload_t mem [FIFO_DEPTH];

    // Write port, enabled on an accepted beat
    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_payload;
        end
    end

    // Read port registered in the read domain
    // Address is the next read pointer, so data lines up with it
    always_ff @(posedge out_clk) begin
        rd_payload <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: dcfifo_ptr_sync.sv
// Pointer clock crossing: Gray encode in the source domain,
// synchronizer chain and binary decode in the destination domain
`default_nettype none

module dcfifo_ptr_sync
    import dcfifo_pkg::*;
#(
    parameter int SYNC_DEPTH = 2
) (
    input  wire  src_clk,
    input  wire  src_reset_n,
    input  wire  dst_clk,
    input  wire  dst_reset_n,
    input  wire  ptr_t src_ptr,
    output ptr_t dst_ptr
);

    // Only one bit changes per pointer step
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at and above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
        for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    ptr_t src_gray;
    ptr_t sync_q [SYNC_DEPTH];

    // Registered Gray code, no glitches leave the source domain
    always_ff @(posedge src_clk or negedge src_reset_n) begin
        if (!src_reset_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= bin2gray(src_ptr);
        end
    end

    // ----------------------------------------------------------
    // Synchronizer chain in the destination domain
    // ----------------------------------------------------------
    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            for (int i = 0; i < SYNC_DEPTH; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= src_gray;
            for (int i = 1; i < SYNC_DEPTH; i++) begin
                sync_q[i] <= sync_q[i - 1];
            end
        end
    end

    // Last stage is stable, decode back to binary
    assign dst_ptr = gray2bin(sync_q[SYNC_DEPTH - 1]);

endmodule

`default_nettype wire

// File: dcfifo_pkg.sv
// Shared widths, types and CSR address map of the dual-clock FIFO
// Payload word layout is {sop, eop, data}
`default_nettype none

package dcfifo_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int DATA_WIDTH      = 8;
    localparam int ADDR_WIDTH      = 4;
    localparam int FIFO_DEPTH      = 1 << ADDR_WIDTH;
    // Data beat plus start-of-packet and end-of-packet flags
    localparam int PAYLOAD_WIDTH   = DATA_WIDTH + 2;
    // Fill level reaches 17 with the output stage counted
    localparam int LEVEL_WIDTH     = ADDR_WIDTH + 1;
    localparam int CSR_DATA_WIDTH  = 32;
    localparam int THRESHOLD_WIDTH = 24;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [PAYLOAD_WIDTH-1:0]   payload_t;
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    // Extra top bit tells full from empty, also used for Gray code
    typedef logic [ADDR_WIDTH:0]        ptr_t;
    typedef logic [LEVEL_WIDTH-1:0]     level_t;
    typedef logic [CSR_DATA_WIDTH-1:0]  csr_data_t;
    typedef logic [THRESHOLD_WIDTH-1:0] threshold_t;

    // ----------------------------------------------------------
    // CSR address map, same on both sides
    // ----------------------------------------------------------
    // Read only fill level
    localparam logic CSR_ADDR_LEVEL     = 1'b0;
    // Read/write almost-full or almost-empty threshold
    localparam logic CSR_ADDR_THRESHOLD = 1'b1;

endpackage

`default_nettype wire
